// ==== src/cdc_pkg.sv ====
//**************************************************************************
// Shared constants for the status/event crossing block
// Widths, register map and AXI response codes
//**************************************************************************

package cdc_pkg;

  //**************************************************************************
  // Crossing widths
  //**************************************************************************
  localparam int STATUS_W    = 8;  // Status levels copied across
  localparam int EVENT_W     = 8;  // Event lines turned into pulses
  localparam int SYNC_STAGES = 2;  // Flops per synchronizer chain

  //**************************************************************************
  // AXI4-Lite bus
  //**************************************************************************
  localparam int ADDR_W = 4;
  localparam int DATA_W = 32;

  // Register map, byte addresses
  localparam logic [ADDR_W-1:0] ADDR_STATUS = 4'h0;  // RO, synced status
  localparam logic [ADDR_W-1:0] ADDR_EVENT  = 4'h4;  // W1C sticky events
  localparam logic [ADDR_W-1:0] ADDR_IRQ_EN = 4'h8;  // RW interrupt mask
  localparam logic [ADDR_W-1:0] ADDR_ID     = 4'hC;  // RO identification

  localparam logic [DATA_W-1:0] ID_VALUE = 32'h1C0DE5A1;

  // Response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== src/reg_if.sv ====
//**************************************************************************
// Register access channel from the bus slave to the register block
//**************************************************************************

`timescale 1ns/1ps

interface reg_if;
  import cdc_pkg::*;

  logic              req;    // One-cycle access strobe
  logic              wr;     // 1 write, 0 read
  logic [ADDR_W-1:0] addr;   // Byte address
  logic [DATA_W-1:0] wdata;  // Write data
  logic [DATA_W-1:0] rdata;  // Read data, combinational from addr
  logic              err;    // Unmapped or read-only target

  // Bus side
  modport master (
    output req, wr, addr, wdata,
    input  rdata, err
  );

  // Register side
  modport slave (
    input  req, wr, addr, wdata,
    output rdata, err
  );

endinterface

// ==== src/cdc_bitsync.sv ====
//**************************************************************************
// Multi-flop synchronizer for independent single-bit signals
//**************************************************************************

`timescale 1ns/1ps

module cdc_bitsync #(
  parameter int DWIDTH = 1  // Number of independent bits
) (
  input  logic              clk,       // Destination clock
  input  logic              rst_n,     // Destination reset
  input  logic [DWIDTH-1:0] data_in,   // Asynchronous inputs
  output logic [DWIDTH-1:0] data_out   // Synchronized outputs
);
  import cdc_pkg::*;

  // First stage may go metastable, keep it next to the second in placement
  (* async_reg = "true" *) logic [DWIDTH-1:0] meta_q;
  logic [SYNC_STAGES-2:0][DWIDTH-1:0] chain_q;  // Remaining stages

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      meta_q  <= '0;
      chain_q <= '0;
    end else begin
      meta_q     <= data_in;
      chain_q[0] <= meta_q;
      for (int s = 1; s < SYNC_STAGES - 1; s++) begin
        chain_q[s] <= chain_q[s-1];  // Extra settling stages
      end
    end
  end

  assign data_out = chain_q[SYNC_STAGES-2];

  // Whole chain flushed by one reset cycle
  a_reset_clear: assert property (@(posedge clk) !rst_n |=> (data_out == '0));

endmodule

// ==== src/cdc_lvlsync.sv ====
//**************************************************************************
// Level/pulse synchronizer, one toggle request/acknowledge per bit
// Level mode copies the input, pulse mode flags each rising edge
//**************************************************************************

`timescale 1ns/1ps

module cdc_lvlsync #(
  parameter int DWIDTH        = 1,    // Bits crossed
  parameter bit EN_PULSE_MODE = 1'b0  // 1: one-cycle pulse per rising edge
) (
  input  logic              wr_clk,    // Source clock
  input  logic              rd_clk,    // Destination clock
  input  logic              wr_rst_n,  // Source reset
  input  logic              rd_rst_n,  // Destination reset
  input  logic [DWIDTH-1:0] data_in,   // Source domain levels
  output logic [DWIDTH-1:0] data_out   // Destination domain levels or pulses
);

  logic [DWIDTH-1:0] data_in_q;  // Value last sent, wr_clk
  logic [DWIDTH-1:0] req_wr;     // Request toggle, wr_clk
  logic [DWIDTH-1:0] ack_wr;     // Acknowledge seen in wr_clk
  logic [DWIDTH-1:0] req_rd;     // Request seen in rd_clk
  logic [DWIDTH-1:0] req_rd_d;   // Delayed request, doubles as acknowledge

  //**************************************************************************
  // Synchronizers, request forward and acknowledge back
  //**************************************************************************
  cdc_bitsync #(
    .DWIDTH (DWIDTH)
  ) req_sync_u (
    .clk      (rd_clk),
    .rst_n    (rd_rst_n),
    .data_in  (req_wr),
    .data_out (req_rd)
  );

  cdc_bitsync #(
    .DWIDTH (DWIDTH)
  ) ack_sync_u (
    .clk      (wr_clk),
    .rst_n    (wr_rst_n),
    .data_in  (req_rd_d),  // Ack is the request once taken in rd_clk
    .data_out (ack_wr)
  );

  //**************************************************************************
  // Per-bit handshake
  //**************************************************************************
  for (genvar i = 0; i < DWIDTH; i++) begin : g_bit
    logic idle_wr;    // No crossing in flight
    logic change_wr;  // Input differs from value sent

    assign idle_wr = (req_wr[i] == ack_wr[i]);
    // Pulse mode only reports rising edges
    assign change_wr = (data_in[i] != data_in_q[i]) && (!EN_PULSE_MODE || data_in[i]);

    // Source side, sample and toggle while idle
    always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
        data_in_q[i] <= 1'b0;
        req_wr[i]    <= 1'b0;
      end else if (idle_wr) begin
        data_in_q[i] <= data_in[i];
        if (change_wr) begin
          req_wr[i] <= ~req_wr[i];  // Launch a crossing
        end
      end
    end

    // Destination side, edge detect on the synchronized request
    always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
        req_rd_d[i] <= 1'b0;
        data_out[i] <= 1'b0;
      end else begin
        req_rd_d[i] <= req_rd[i];
        if (EN_PULSE_MODE) begin
          data_out[i] <= (req_rd[i] != req_rd_d[i]);  // Single cycle strobe
        end else if (req_rd[i] != req_rd_d[i]) begin
          data_out[i] <= ~data_out[i];                // Follow the source value
        end
      end
    end

    // A new request only after the previous one came back
    a_req_after_ack: assert property (
      @(posedge wr_clk) disable iff (!wr_rst_n)
      $changed(req_wr[i]) |-> $past(idle_wr)
    );

    if (EN_PULSE_MODE) begin : g_pulse_chk
      // Round trip is long, so pulses never merge
      a_pulse_single: assert property (
        @(posedge rd_clk) disable iff (!rd_rst_n)
        data_out[i] |=> !data_out[i]
      );
    end
  end

endmodule

// ==== src/axil_reg_port.sv ====
//**************************************************************************
// AXI4-Lite slave, one transaction at a time
// Each accepted transfer becomes a single register access strobe
//**************************************************************************

`timescale 1ns/1ps

module axil_reg_port (
  input  logic                       rd_clk,
  input  logic                       rd_rst_n,
  // Write address
  input  logic                       awvalid,
  output logic                       awready,
  input  logic [cdc_pkg::ADDR_W-1:0] awaddr,
  // Write data
  input  logic                       wvalid,
  output logic                       wready,
  input  logic [cdc_pkg::DATA_W-1:0] wdata,
  input  logic [cdc_pkg::DATA_W/8-1:0] wstrb,  // Full-word writes only, strobes ignored
  // Write response
  output logic                       bvalid,
  input  logic                       bready,
  output logic [1:0]                 bresp,
  // Read address
  input  logic                       arvalid,
  output logic                       arready,
  input  logic [cdc_pkg::ADDR_W-1:0] araddr,
  // Read data
  output logic                       rvalid,
  input  logic                       rready,
  output logic [cdc_pkg::DATA_W-1:0] rdata,
  output logic [1:0]                 rresp,
  // Register access
  reg_if.master                      bus
);
  import cdc_pkg::*;

  logic rd_accept;  // Read taken this cycle
  logic wr_accept;  // Write taken this cycle

  //**************************************************************************
  // Acceptance, reads win a tie
  //**************************************************************************
  assign rd_accept = arvalid && !rvalid;
  assign wr_accept = awvalid && wvalid && !bvalid && !rd_accept;

  assign arready = rd_accept;
  assign awready = wr_accept;  // Address and data taken together
  assign wready  = wr_accept;

  // One strobe per transaction
  assign bus.req   = rd_accept || wr_accept;
  assign bus.wr    = wr_accept;
  assign bus.addr  = rd_accept ? araddr : awaddr;
  assign bus.wdata = wdata;

  //**************************************************************************
  // Response channels
  //**************************************************************************
  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (wr_accept) bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;  // Response taken
      if (rd_accept) rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
    end
  end

  // Payload captured on the access edge, held while stalled
  always_ff @(posedge rd_clk) begin
    if (wr_accept) begin
      bresp <= bus.err ? RESP_SLVERR : RESP_OKAY;
    end
    if (rd_accept) begin
      rdata <= bus.rdata;
      rresp <= bus.err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // Responses stay up and steady until taken
  a_b_hold: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp)
  );
  a_r_hold: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
  );

endmodule

// ==== src/status_regs.sv ====
//**************************************************************************
// Status, sticky event, interrupt enable and ID registers
// Interrupt is the OR of enabled sticky events
//**************************************************************************

`timescale 1ns/1ps

module status_regs (
  input  logic                         rd_clk,
  input  logic                         rd_rst_n,
  input  logic [cdc_pkg::STATUS_W-1:0] status_sync,  // Level synchronizer output
  input  logic [cdc_pkg::EVENT_W-1:0]  event_pulse,  // Pulse synchronizer output
  reg_if.slave                         bus,
  output logic                         irq
);
  import cdc_pkg::*;

  logic [EVENT_W-1:0] event_q;   // Sticky event bits
  logic [EVENT_W-1:0] irq_en_q;  // Interrupt mask
  logic [EVENT_W-1:0] clr_mask;  // W1C mask this cycle
  logic               en_write;  // Mask update this cycle

  //**************************************************************************
  // Read decode
  //**************************************************************************
  always_comb begin
    bus.rdata = '0;
    bus.err   = 1'b0;
    case (bus.addr)
      ADDR_STATUS: begin
        bus.rdata = DATA_W'(status_sync);
        bus.err   = bus.wr;  // Read only
      end
      ADDR_EVENT:  bus.rdata = DATA_W'(event_q);
      ADDR_IRQ_EN: bus.rdata = DATA_W'(irq_en_q);
      ADDR_ID: begin
        bus.rdata = ID_VALUE;
        bus.err   = bus.wr;
      end
      default:     bus.err = 1'b1;  // Unmapped
    endcase
  end

  // Write strobes
  assign clr_mask = (bus.req && bus.wr && bus.addr == ADDR_EVENT) ?
                    bus.wdata[EVENT_W-1:0] : '0;
  assign en_write = bus.req && bus.wr && (bus.addr == ADDR_IRQ_EN);

  //**************************************************************************
  // Registers
  //**************************************************************************
  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      event_q  <= '0;
      irq_en_q <= '0;
      irq      <= 1'b0;
    end else begin
      event_q <= (event_q & ~clr_mask) | event_pulse;  // New event beats a clear
      if (en_write) irq_en_q <= bus.wdata[EVENT_W-1:0];
      irq <= |(event_q & irq_en_q);
    end
  end

  // Masked off means quiet on the next cycle
  a_irq_masked: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    (irq_en_q == '0) |=> !irq
  );

endmodule

// ==== src/cdc_status_top.sv ====
//**************************************************************************
// Status/event crossing into the read domain with AXI4-Lite access
//**************************************************************************

`timescale 1ns/1ps

module cdc_status_top (
  // Write domain
  input  logic                         wr_clk,
  input  logic                         wr_rst_n,
  input  logic [cdc_pkg::STATUS_W-1:0] status_in,
  input  logic [cdc_pkg::EVENT_W-1:0]  event_in,
  // Read domain
  input  logic                         rd_clk,
  input  logic                         rd_rst_n,
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [cdc_pkg::ADDR_W-1:0]   awaddr,
  input  logic                         wvalid,
  output logic                         wready,
  input  logic [cdc_pkg::DATA_W-1:0]   wdata,
  input  logic [cdc_pkg::DATA_W/8-1:0] wstrb,
  output logic                         bvalid,
  input  logic                         bready,
  output logic [1:0]                   bresp,
  input  logic                         arvalid,
  output logic                         arready,
  input  logic [cdc_pkg::ADDR_W-1:0]   araddr,
  output logic                         rvalid,
  input  logic                         rready,
  output logic [cdc_pkg::DATA_W-1:0]   rdata,
  output logic [1:0]                   rresp,
  output logic                         irq
);
  import cdc_pkg::*;

  logic [STATUS_W-1:0] status_sync;  // Status in rd_clk
  logic [EVENT_W-1:0]  event_pulse;  // Event strobes in rd_clk

  reg_if reg_bus ();

  //**************************************************************************
  // Crossings
  //**************************************************************************
  cdc_lvlsync #(
    .DWIDTH        (STATUS_W),
    .EN_PULSE_MODE (1'b0)
  ) status_sync_u (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .rd_rst_n (rd_rst_n),
    .data_in  (status_in),
    .data_out (status_sync)
  );

  cdc_lvlsync #(
    .DWIDTH        (EVENT_W),
    .EN_PULSE_MODE (1'b1)
  ) event_sync_u (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .rd_rst_n (rd_rst_n),
    .data_in  (event_in),
    .data_out (event_pulse)
  );

  //**************************************************************************
  // Bus slave and registers
  //**************************************************************************
  axil_reg_port axil_reg_port_u (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .awvalid  (awvalid),
    .awready  (awready),
    .awaddr   (awaddr),
    .wvalid   (wvalid),
    .wready   (wready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .bvalid   (bvalid),
    .bready   (bready),
    .bresp    (bresp),
    .arvalid  (arvalid),
    .arready  (arready),
    .araddr   (araddr),
    .rvalid   (rvalid),
    .rready   (rready),
    .rdata    (rdata),
    .rresp    (rresp),
    .bus      (reg_bus.master)
  );

  status_regs status_regs_u (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .status_sync (status_sync),
    .event_pulse (event_pulse),
    .bus         (reg_bus.slave),
    .irq         (irq)
  );

endmodule

// ==== bench/tb_cdc_status.sv ====
//**************************************************************************
// Testbench for the status/event crossing block
// Steps from a table drive the bus and the write domain
//**************************************************************************

`timescale 1ns/1ps

module tb_cdc_status;
  import cdc_pkg::*;

  localparam int BUS_TIMEOUT = 40;  // rd_clk cycles per handshake
  localparam int POLL_LIMIT  = 20;  // Reads before a poll gives up
  localparam int IRQ_TIMEOUT = 50;
  localparam int EVENT_GAP   = 12;  // wr_clk cycles between event edges

  // Step actions
  localparam logic [2:0] ACT_STATUS = 3'd0;  // Drive status_in
  localparam logic [2:0] ACT_POLL   = 3'd1;  // Read until value matches
  localparam logic [2:0] ACT_EVENT  = 3'd2;  // Raise event bits one by one
  localparam logic [2:0] ACT_WRITE  = 3'd3;
  localparam logic [2:0] ACT_READ   = 3'd4;
  localparam logic [2:0] ACT_IRQ    = 3'd5;  // Wait for an irq level
  localparam logic [2:0] ACT_QUIET  = 3'd6;  // irq holds for data cycles

  typedef struct packed {
    logic [2:0]        act;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] exp;   // Read data or irq level
    logic [1:0]        resp;
  } step_t;

  logic                wr_clk;
  logic                wr_rst_n;
  logic [STATUS_W-1:0] status_in;
  logic [EVENT_W-1:0]  event_in;
  logic                rd_clk;
  logic                rd_rst_n;
  logic                awvalid;
  logic                awready;
  logic [ADDR_W-1:0]   awaddr;
  logic                wvalid;
  logic                wready;
  logic [DATA_W-1:0]   wdata;
  logic [DATA_W/8-1:0] wstrb;
  logic                bvalid;
  logic                bready;
  logic [1:0]          bresp;
  logic                arvalid;
  logic                arready;
  logic [ADDR_W-1:0]   araddr;
  logic                rvalid;
  logic                rready;
  logic [DATA_W-1:0]   rdata;
  logic [1:0]          rresp;
  logic                irq;

  step_t             steps[$];     // Stimulus table
  logic [DATA_W-1:0] rand_status;  // Random level for the second crossing

  cdc_status_top cdc_status_top_i (.*);

  // Unrelated clocks
  initial begin
    rd_clk = 1'b0;
    forever #50 rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #35 wr_clk = ~wr_clk;
  end

  //**************************************************************************
  // Checks and failures
  //**************************************************************************
  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s: got 0x%08h expected 0x%08h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  function automatic void add_step(input logic [2:0] act, input logic [ADDR_W-1:0] addr,
                                   input logic [DATA_W-1:0] data,
                                   input logic [DATA_W-1:0] exp, input logic [1:0] resp);
    step_t s;
    s.act  = act;
    s.addr = addr;
    s.data = data;
    s.exp  = exp;
    s.resp = resp;
    steps.push_back(s);
  endfunction

  //**************************************************************************
  // AXI4-Lite master tasks
  //**************************************************************************
  task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            output logic [1:0] resp);
    int         cycles;
    int         stall;
    logic [1:0] first_resp;
    stall = $urandom % 6;  // bready held low this long
    @(posedge rd_clk);
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= '1;
    cycles = 0;
    @(negedge rd_clk);
    while (!(awready && wready)) begin
      cycles++;
      if (cycles > BUS_TIMEOUT) report_failure("timeout waiting for awready and wready");
      @(negedge rd_clk);
    end
    @(posedge rd_clk);  // Handshake edge
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    cycles = 0;
    @(negedge rd_clk);
    while (!bvalid) begin
      cycles++;
      if (cycles > BUS_TIMEOUT) report_failure("timeout waiting for bvalid");
      @(negedge rd_clk);
    end
    first_resp = bresp;
    repeat (stall) begin
      @(negedge rd_clk);
      check_equal("bvalid", 32'(bvalid), 32'h1);
      check_equal("bresp", 32'(bresp), 32'(first_resp));
    end
    @(posedge rd_clk);
    bready <= 1'b1;
    @(posedge rd_clk);  // Response taken here
    bready <= 1'b0;
    resp = first_resp;
  endtask

  task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                           output logic [1:0] resp);
    int                cycles;
    int                stall;
    logic [DATA_W-1:0] first_data;
    logic [1:0]        first_resp;
    stall = $urandom % 6;
    @(posedge rd_clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    cycles = 0;
    @(negedge rd_clk);
    while (!arready) begin
      cycles++;
      if (cycles > BUS_TIMEOUT) report_failure("timeout waiting for arready");
      @(negedge rd_clk);
    end
    @(posedge rd_clk);
    arvalid <= 1'b0;
    cycles = 0;
    @(negedge rd_clk);
    while (!rvalid) begin
      cycles++;
      if (cycles > BUS_TIMEOUT) report_failure("timeout waiting for rvalid");
      @(negedge rd_clk);
    end
    first_data = rdata;
    first_resp = rresp;
    repeat (stall) begin  // Stalled response must not move
      @(negedge rd_clk);
      check_equal("rvalid", 32'(rvalid), 32'h1);
      check_equal("rdata", rdata, first_data);
      check_equal("rresp", 32'(rresp), 32'(first_resp));
    end
    @(posedge rd_clk);
    rready <= 1'b1;
    @(posedge rd_clk);
    rready <= 1'b0;
    data = first_data;
    resp = first_resp;
  endtask

  //**************************************************************************
  // Write-domain stimulus and irq waits
  //**************************************************************************
  task automatic raise_events(input logic [EVENT_W-1:0] bits);
    for (int b = 0; b < EVENT_W; b++) begin
      if (bits[b]) begin
        @(posedge wr_clk);
        event_in[b] <= 1'b1;  // Held high until all are up
        repeat (EVENT_GAP) @(posedge wr_clk);
      end
    end
    @(posedge wr_clk);
    event_in <= '0;
  endtask

  task automatic wait_irq(input logic level);
    int cycles;
    cycles = 0;
    @(negedge rd_clk);
    while (irq !== level) begin
      cycles++;
      if (cycles > IRQ_TIMEOUT) report_failure("timeout waiting for irq to change");
      @(negedge rd_clk);
    end
  endtask

  task automatic apply_step(input step_t s);
    logic [DATA_W-1:0] got_data;
    logic [1:0]        got_resp;
    int                tries;
    case (s.act)
      ACT_STATUS: begin
        @(posedge wr_clk);
        status_in <= s.data[STATUS_W-1:0];
      end
      ACT_POLL: begin
        tries = 0;
        axil_read(s.addr, got_data, got_resp);
        while (got_data !== s.exp) begin  // Crossing latency is not fixed
          tries++;
          if (tries > POLL_LIMIT) report_failure("polled register never showed the expected value");
          axil_read(s.addr, got_data, got_resp);
        end
        check_equal("rresp", 32'(got_resp), 32'(s.resp));
      end
      ACT_EVENT: raise_events(s.data[EVENT_W-1:0]);
      ACT_WRITE: begin
        axil_write(s.addr, s.data, got_resp);
        check_equal("bresp", 32'(got_resp), 32'(s.resp));
      end
      ACT_READ: begin
        axil_read(s.addr, got_data, got_resp);
        check_equal("rresp", 32'(got_resp), 32'(s.resp));
        if (s.resp == RESP_OKAY) check_equal("rdata", got_data, s.exp);
      end
      ACT_IRQ: wait_irq(s.exp[0]);
      ACT_QUIET: begin
        repeat (s.data) begin
          @(negedge rd_clk);
          check_equal("irq", 32'(irq), s.exp);
        end
      end
      default: report_failure("unknown action in the stimulus table");
    endcase
  endtask

  //**************************************************************************
  // Main sequence
  //**************************************************************************
  initial begin
    wr_rst_n  <= 1'b0;
    rd_rst_n  <= 1'b0;
    status_in <= '0;
    event_in  <= '0;
    awvalid   <= 1'b0;
    awaddr    <= '0;
    wvalid    <= 1'b0;
    wdata     <= '0;
    wstrb     <= '0;
    bready    <= 1'b0;
    arvalid   <= 1'b0;
    araddr    <= '0;
    rready    <= 1'b0;
    void'($urandom(32'h832cf78a));
    rand_status = DATA_W'($urandom % 256);
    if (rand_status == 32'h5A) rand_status = 32'hA5;  // Must differ from the first level

    // Reset state
    add_step(ACT_READ,   ADDR_ID,     32'h0,       ID_VALUE,    RESP_OKAY);
    add_step(ACT_READ,   ADDR_STATUS, 32'h0,       32'h0,       RESP_OKAY);
    add_step(ACT_READ,   ADDR_EVENT,  32'h0,       32'h0,       RESP_OKAY);
    add_step(ACT_QUIET,  4'h0,        32'd5,       32'h0,       RESP_OKAY);
    // Level crossing with a fixed then a random value
    add_step(ACT_STATUS, 4'h0,        32'h5A,      32'h0,       RESP_OKAY);
    add_step(ACT_POLL,   ADDR_STATUS, 32'h0,       32'h5A,      RESP_OKAY);
    add_step(ACT_STATUS, 4'h0,        rand_status, 32'h0,       RESP_OKAY);
    add_step(ACT_POLL,   ADDR_STATUS, 32'h0,       rand_status, RESP_OKAY);
    // Sticky events while irq is masked
    add_step(ACT_EVENT,  4'h0,        32'h29,      32'h0,       RESP_OKAY);
    add_step(ACT_POLL,   ADDR_EVENT,  32'h0,       32'h29,      RESP_OKAY);
    add_step(ACT_QUIET,  4'h0,        32'd8,       32'h0,       RESP_OKAY);
    // Enable overlaps bit 3
    add_step(ACT_WRITE,  ADDR_IRQ_EN, 32'h0C,      32'h0,       RESP_OKAY);
    add_step(ACT_IRQ,    4'h0,        32'h0,       32'h1,       RESP_OKAY);
    add_step(ACT_READ,   ADDR_IRQ_EN, 32'h0,       32'h0C,      RESP_OKAY);
    add_step(ACT_WRITE,  ADDR_EVENT,  32'h21,      32'h0,       RESP_OKAY);  // Bits 0 and 5
    add_step(ACT_READ,   ADDR_EVENT,  32'h0,       32'h08,      RESP_OKAY);
    add_step(ACT_QUIET,  4'h0,        32'd4,       32'h1,       RESP_OKAY);
    add_step(ACT_WRITE,  ADDR_EVENT,  32'h08,      32'h0,       RESP_OKAY);
    add_step(ACT_IRQ,    4'h0,        32'h0,       32'h0,       RESP_OKAY);
    add_step(ACT_READ,   ADDR_EVENT,  32'h0,       32'h0,       RESP_OKAY);
    // Error responses leave contents alone
    add_step(ACT_READ,   4'h2,        32'h0,       32'h0,       RESP_SLVERR);
    add_step(ACT_WRITE,  ADDR_STATUS, 32'hFF,      32'h0,       RESP_SLVERR);
    add_step(ACT_READ,   ADDR_STATUS, 32'h0,       rand_status, RESP_OKAY);
    add_step(ACT_WRITE,  ADDR_ID,     32'h0,       32'h0,       RESP_SLVERR);
    add_step(ACT_READ,   ADDR_ID,     32'h0,       ID_VALUE,    RESP_OKAY);
    add_step(ACT_WRITE,  4'h6,        32'hFF,      32'h0,       RESP_SLVERR);
    add_step(ACT_READ,   ADDR_IRQ_EN, 32'h0,       32'h0C,      RESP_OKAY);

    fork
      begin
        repeat (3) @(posedge wr_clk);
        wr_rst_n <= 1'b1;
      end
      begin
        repeat (3) @(posedge rd_clk);
        rd_rst_n <= 1'b1;
      end
    join
    repeat (2) @(posedge rd_clk);

    // Bus handshake outputs idle out of reset
    @(negedge rd_clk);
    check_equal("awready", 32'(awready), 32'h0);
    check_equal("wready", 32'(wready), 32'h0);
    check_equal("arready", 32'(arready), 32'h0);
    check_equal("bvalid", 32'(bvalid), 32'h0);
    check_equal("rvalid", 32'(rvalid), 32'h0);

    for (int i = 0; i < steps.size(); i++) begin
      apply_step(steps[i]);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== flist.f ====
src/cdc_pkg.sv
src/reg_if.sv
src/cdc_bitsync.sv
src/cdc_lvlsync.sv
src/axil_reg_port.sv
src/status_regs.sv
src/cdc_status_top.sv
bench/tb_cdc_status.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Verilator build and run of the status crossing testbench
# Exit status follows the pass line in the simulation output

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module tb_cdc_status -f flist.f &&
  ./obj_dir/Vtb_cdc_status | tee /dev/stderr | grep -q '^TEST OK$' &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
exit 0
